// ==== sources.f ====
+incdir+source
+incdir+bench
source/mmuPkg.sv
source/tlbEntryArray.sv
source/tlbScanCounter.sv
source/refillControl.sv
source/dataTlbStage.sv
source/dataMmu.sv
bench/dataMmuTb.sv

// ==== Bender.yml ====
package:
  name: data_mmu

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mmuPkg.sv
      - source/tlbEntryArray.sv
      - source/tlbScanCounter.sv
      - source/refillControl.sv
      - source/dataTlbStage.sv
      - source/dataMmu.sv
  - target: simulation
    include_dirs:
      - source
      - bench
    files:
      - bench/dataMmuTb.sv

// ==== bench/dataMmuVectors.svh ====
`ifndef DATA_MMU_VECTORS_SVH
`define DATA_MMU_VECTORS_SVH

typedef enum logic [1:0] {
    opWrite,
    opFlush,
    opAccess
} rowOp_e;

// where the expected pfn of an access row comes from
typedef enum logic [1:0] {
    pfnNone,
    pfnTable,
    pfnShadow
} pfnSource_e;

typedef struct packed {
    rowOp_e                op;
    logic [2:0]            index;
    logic [19:0]           vpn;
    logic                  read;
    logic                  store;
    logic [2:0]            k0Attr;
    logic [2:0]            c0;
    logic                  d0;
    logic                  v0;
    logic [2:0]            c1;
    logic                  d1;
    logic                  v1;
    pfnSource_e            pfnSrc;
    logic [19:0]           expPfn;
    logic                  expUncached;
    mmuPkg::tlbException_e expEx;
    logic [3:0]            expStall;
} vecRow_t;

vecRow_t vectors [$];
string   rowNames [$];

function automatic void addWrite(string name, logic [2:0] index, logic [19:0] vpn,
                                 logic [2:0] c0, logic d0, logic v0,
                                 logic [2:0] c1, logic d1, logic v1);
    vecRow_t row;
    row       = '0;
    row.op    = opWrite;
    row.index = index;
    row.vpn   = vpn; // vpn2 taken from bits 19..1
    row.c0    = c0;
    row.d0    = d0;
    row.v0    = v0;
    row.c1    = c1;
    row.d1    = d1;
    row.v1    = v1;
    vectors.push_back(row);
    rowNames.push_back(name);
endfunction

function automatic void addFlush(string name);
    vecRow_t row;
    row    = '0;
    row.op = opFlush;
    vectors.push_back(row);
    rowNames.push_back(name);
endfunction

function automatic void addAccess(string name, logic [19:0] vpn, logic read, logic store,
                                  logic [2:0] k0Attr, pfnSource_e pfnSrc,
                                  logic [19:0] expPfn, logic expUncached,
                                  mmuPkg::tlbException_e expEx, int expStall);
    vecRow_t row;
    row             = '0;
    row.op          = opAccess;
    row.vpn         = vpn;
    row.read        = read;
    row.store       = store;
    row.k0Attr      = k0Attr;
    row.pfnSrc      = pfnSrc;
    row.expPfn      = expPfn;
    row.expUncached = expUncached;
    row.expEx       = expEx;
    row.expStall    = expStall[3:0];
    vectors.push_back(row);
    rowNames.push_back(name);
endfunction

// stall of a mapped miss is index+2, or 9 when nothing matches
function automatic void buildTable();
    addAccess("kseg0 cached read", 20'h81234, 1, 0, 3'd3, pfnTable, 20'h01234, 0,
              mmuPkg::noEx, 0);
    addAccess("kseg0 uncached store", 20'h9ABCD, 0, 1, 3'd2, pfnTable, 20'h1ABCD, 1,
              mmuPkg::noEx, 0);
    addAccess("kseg1 read", 20'hA5678, 1, 0, 3'd3, pfnTable, 20'h05678, 1, mmuPkg::noEx, 0);
    addAccess("kseg1 store", 20'hBFEDC, 0, 1, 3'd3, pfnTable, 20'h1FEDC, 1, mmuPkg::noEx, 0);
    addWrite("write index 0", 3'd0, 20'h00400, 3'd3, 1, 1, 3'd2, 1, 1);
    addWrite("write index 3", 3'd3, 20'hC0010, 3'd3, 0, 1, 3'd3, 1, 0);
    addWrite("write index 5", 3'd5, 20'h12344, 3'd3, 1, 1, 3'd3, 1, 1);
    addWrite("write index 7", 3'd7, 20'h7FFE0, 3'd2, 1, 1, 3'd3, 1, 1);
    addFlush("flush after writes");
    addAccess("hit index 0 even", 20'h00400, 1, 0, 3'd3, pfnShadow, '0, 0, mmuPkg::noEx, 2);
    addAccess("hit index 0 odd", 20'h00401, 1, 0, 3'd3, pfnShadow, '0, 1, mmuPkg::noEx, 0);
    addAccess("hit index 5 store", 20'h12345, 0, 1, 3'd3, pfnShadow, '0, 0, mmuPkg::noEx, 7);
    addAccess("hit index 7", 20'h7FFE0, 1, 0, 3'd3, pfnShadow, '0, 1, mmuPkg::noEx, 9);
    addAccess("read refill", 20'h33330, 1, 0, 3'd3, pfnNone, '0, 0, mmuPkg::rdRefill, 9);
    addAccess("store refill", 20'h44440, 0, 1, 3'd3, pfnNone, '0, 0, mmuPkg::wrRefill, 9);
    addAccess("read invalid", 20'hC0011, 1, 0, 3'd3, pfnShadow, '0, 0,
              mmuPkg::rdInvalid, 5);
    addAccess("store invalid", 20'hC0011, 0, 1, 3'd3, pfnShadow, '0, 0,
              mmuPkg::wrInvalid, 0);
    addAccess("store clean page", 20'hC0010, 0, 1, 3'd3, pfnShadow, '0, 0,
              mmuPkg::modified, 0);
    addAccess("read clean page", 20'hC0010, 1, 0, 3'd3, pfnShadow, '0, 0, mmuPkg::noEx, 0);
    addAccess("no access", 20'h55550, 0, 0, 3'd3, pfnNone, '0, 0, mmuPkg::noEx, 0);
    addFlush("flush buffer");
    addAccess("refetch after flush", 20'hC0010, 1, 0, 3'd3, pfnShadow, '0, 0,
              mmuPkg::noEx, 5);
    addAccess("buffered again", 20'hC0010, 1, 0, 3'd3, pfnShadow, '0, 0, mmuPkg::noEx, 0);
    addWrite("rewrite index 3", 3'd3, 20'hC0010, 3'd3, 1, 1, 3'd3, 1, 1);
    addFlush("flush after rewrite");
    addAccess("new pfn store", 20'hC0010, 0, 1, 3'd3, pfnShadow, '0, 0, mmuPkg::noEx, 5);
endfunction

`endif

// ==== bench/dataMmuTb.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module dataMmuTb;

    logic                 clk;
    logic                 reset;
    mmuPkg::dataAccess_t  access;
    logic [2:0]           k0Attr;
    logic                 flush;
    logic                 writeStrobe;
    mmuPkg::tlbWrite_t    tlbWrite;
    mmuPkg::translation_t result;
    logic                 stall;

    `include "dataMmuVectors.svh"

    mmuPkg::tlbEntry_t shadow [`TLB_ENTRIES]; // entries as written by the table
    int                cycleCount;
    int                cycleLimit;

    dataMmu i_dut (
        .clk         (clk),
        .reset       (reset),
        .access      (access),
        .k0Attr      (k0Attr),
        .flush       (flush),
        .writeStrobe (writeStrobe),
        .tlbWrite    (tlbWrite),
        .result      (result),
        .stall       (stall)
    );

    always #2 clk = ~clk;

    task automatic abortRun();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("run took more than %0d cycles, the DUT stopped responding", cycleLimit);
            abortRun();
        end
    end

    task automatic expectEqual(string name, string what, logic [31:0] expected,
                               logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s: %s expected 0x%0h actual 0x%0h", name, what, expected, actual);
            abortRun();
        end
    endtask

    // lowest matching index wins like the scan does
    function automatic logic [19:0] shadowPfn(logic [19:0] vpn);
        logic [19:0] pfn;
        pfn = 'x;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (shadow[i].vpn2 == vpn[19:1]) begin
                pfn = vpn[0] ? shadow[i].pfn1 : shadow[i].pfn0;
            end
        end
        return pfn;
    endfunction

    task automatic writeEntry(vecRow_t row);
        mmuPkg::tlbEntry_t entry;
        entry.vpn2     = row.vpn[19:1];
        entry.pfn0     = 20'($urandom);
        entry.c0       = row.c0;
        entry.d0       = row.d0;
        entry.v0       = row.v0;
        entry.pfn1     = 20'($urandom);
        entry.c1       = row.c1;
        entry.d1       = row.d1;
        entry.v1       = row.v1;
        shadow[row.index] = entry;
        tlbWrite.index = row.index;
        tlbWrite.entry = entry;
        writeStrobe    = 1'b1;
        @(posedge clk);
        #0.5 writeStrobe = 1'b0;
    endtask

    task automatic runAccess(vecRow_t row, string name);
        int          stallCycles;
        logic [19:0] pfnExp;
        stallCycles  = 0;
        access.vpn   = row.vpn;
        access.read  = row.read;
        access.store = row.store;
        k0Attr       = row.k0Attr;
        @(negedge clk);
        while (stall) begin // request held until the refill is done
            stallCycles++;
            @(negedge clk);
        end
        expectEqual(name, "stall cycles", row.expStall, stallCycles);
        expectEqual(name, "exception", row.expEx, result.exception);
        expectEqual(name, "ex flag", row.expEx != mmuPkg::noEx, result.ex);
        if (row.pfnSrc != pfnNone) begin
            pfnExp = (row.pfnSrc == pfnShadow) ? shadowPfn(row.vpn) : row.expPfn;
            expectEqual(name, "pfn", pfnExp, result.pfn);
            expectEqual(name, "uncached", row.expUncached, result.uncached);
        end
        @(posedge clk);
        #0.5;
        access.read  = 1'b0;
        access.store = 1'b0;
    endtask

    initial begin
        void'($urandom(59));
        clk         = 1'b0;
        reset       = 1'b1;
        access      = '0;
        k0Attr      = `CACHEABLE_ATTR;
        flush       = 1'b0;
        writeStrobe = 1'b0;
        tlbWrite    = '0;
        cycleCount  = 0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            shadow[i] = '0;
        end
        buildTable();
        cycleLimit = vectors.size() * 12 + 64;

        repeat (16) @(posedge clk);
        #0.5 reset = 1'b0;

        for (int r = 0; r < vectors.size(); r++) begin
            case (vectors[r].op)
                opWrite: writeEntry(vectors[r]);
                opFlush: begin
                    flush = 1'b1;
                    @(posedge clk);
                    #0.5 flush = 1'b0;
                end
                default: runAccess(vectors[r], rowNames[r]);
            endcase
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== source/dataMmu.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module dataMmu (
    input  logic                 clk,
    input  logic                 reset,
    input  mmuPkg::dataAccess_t  access,
    input  logic [2:0]           k0Attr,
    input  logic                 flush,
    input  logic                 writeStrobe,
    input  mmuPkg::tlbWrite_t    tlbWrite,
    output mmuPkg::translation_t result,
    output logic                 stall
);

    logic                    bufferMiss;
    logic                    scanStart;
    logic                    scanActive;
    logic                    bufferLoad;
    logic                    loadFound;
    logic                    entryHit;
    logic                    lastIndex;
    logic [`TLB_INDEX_W-1:0] scanIndex;
    mmuPkg::tlbEntry_t       readEntry;

    assign stall = bufferMiss; // held request waits for the refill

    dataTlbStage stage (
        .clk        (clk),
        .reset      (reset),
        .access     (access),
        .k0Attr     (k0Attr),
        .flush      (flush),
        .bufferLoad (bufferLoad),
        .loadFound  (loadFound),
        .fillEntry  (readEntry),
        .result     (result),
        .bufferMiss (bufferMiss)
    );

    refillControl control (
        .clk         (clk),
        .reset       (reset),
        .bufferMiss  (bufferMiss),
        .entryHit    (entryHit),
        .lastIndex   (lastIndex),
        .writeStrobe (writeStrobe),
        .scanStart   (scanStart),
        .scanActive  (scanActive),
        .bufferLoad  (bufferLoad),
        .loadFound   (loadFound)
    );

    tlbScanCounter counter (
        .clk        (clk),
        .reset      (reset),
        .scanStart  (scanStart),
        .scanActive (scanActive),
        .scanIndex  (scanIndex),
        .lastIndex  (lastIndex)
    );

    tlbEntryArray array (
        .clk         (clk),
        .reset       (reset),
        .writeStrobe (writeStrobe),
        .tlbWrite    (tlbWrite),
        .scanIndex   (scanIndex),
        .vpn2        (access.vpn[19:1]),
        .entryHit    (entryHit),
        .readEntry   (readEntry)
    );

endmodule

// ==== source/dataTlbStage.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module dataTlbStage (
    input  logic                 clk,
    input  logic                 reset,
    input  mmuPkg::dataAccess_t  access,
    input  logic [2:0]           k0Attr,
    input  logic                 flush,
    input  logic                 bufferLoad,
    input  logic                 loadFound,
    input  mmuPkg::tlbEntry_t    fillEntry,
    output mmuPkg::translation_t result,
    output logic                 bufferMiss
);

    mmuPkg::tlbEntry_t bufEntry;
    logic              bufValid;
    logic              bufFound;
    logic              flushPending;
    logic              clearNow;

    logic [3:0]  segment;
    logic        kseg0;
    logic        kseg1;
    logic        unmapped;
    logic        accessReq;
    logic        bufferHit;
    logic        oddPage;
    logic [19:0] selPfn;
    logic [2:0]  selC;
    logic        selD;
    logic        selV;

    assign segment   = access.vpn[19:16]; // address bits 31..28
    assign kseg0     = (segment[3:1] == `KSEG0_HI);
    assign kseg1     = (segment[3:1] == `KSEG1_HI);
    assign unmapped  = kseg0 || kseg1;
    assign accessReq = access.read || access.store;
    assign bufferHit = bufValid && (bufEntry.vpn2 == access.vpn[19:1]);
    assign bufferMiss = !unmapped && accessReq && !bufferHit;

    // even or odd half of the pair
    assign oddPage = access.vpn[0];
    assign selPfn  = oddPage ? bufEntry.pfn1 : bufEntry.pfn0;
    assign selC    = oddPage ? bufEntry.c1 : bufEntry.c0;
    assign selD    = oddPage ? bufEntry.d1 : bufEntry.d0;
    assign selV    = oddPage ? bufEntry.v1 : bufEntry.v0;

    // a flush that arrives while a refill is pending waits until the load is done
    assign clearNow = (flush || flushPending) && !bufferMiss;

    always_ff @(posedge clk) begin
        if (reset) begin
            bufValid     <= 1'b0;
            bufFound     <= 1'b0;
            flushPending <= 1'b0;
        end else begin
            flushPending <= bufferMiss && (flush || flushPending);
            if (bufferLoad) begin
                bufValid <= 1'b1;
                bufFound <= loadFound;
            end else if (clearNow) begin
                bufValid <= 1'b0;
                bufFound <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bufferLoad) begin
            bufEntry      <= fillEntry;
            bufEntry.vpn2 <= access.vpn[19:1]; // tag from the request even for a not-found record
        end
    end

    always_comb begin
        result           = '0;
        result.exception = mmuPkg::noEx;

        if (kseg1) begin
            result.pfn      = {3'b000, access.vpn[16:0]};
            result.uncached = 1'b1;
        end else if (kseg0) begin
            result.pfn      = {1'b0, access.vpn[18:0]};
            result.uncached = (k0Attr != `CACHEABLE_ATTR);
        end else begin
            result.pfn      = selPfn;
            result.uncached = (selC != `CACHEABLE_ATTR);
        end

        // exceptions only for a mapped access that the buffer covers
        if (!unmapped && accessReq && bufferHit) begin
            if (!bufFound) begin
                result.exception = access.read ? mmuPkg::rdRefill : mmuPkg::wrRefill;
            end else if (!selV) begin
                result.exception = access.read ? mmuPkg::rdInvalid : mmuPkg::wrInvalid;
            end else if (access.store && !selD) begin
                result.exception = mmuPkg::modified; // store to clean page
            end
        end

        result.ex = (result.exception != mmuPkg::noEx);
    end

    // the held request must hit once the buffer is loaded
    loadGivesHit: assert property (
        @(posedge clk) disable iff (reset)
        bufferLoad |=> !bufferMiss
    ) else $error("held request still misses after the buffer load");

endmodule

// ==== source/refillControl.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module refillControl (
    input  logic clk,
    input  logic reset,
    input  logic bufferMiss,
    input  logic entryHit,
    input  logic lastIndex,
    input  logic writeStrobe,
    output logic scanStart,
    output logic scanActive,
    output logic bufferLoad,
    output logic loadFound
);

    typedef enum logic {
        idleState,
        scanState
    } ctrlState_t;

    ctrlState_t state;
    ctrlState_t nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idleState;
        end else begin
            state <= nextState;
        end
    end

    assign scanActive = (state == scanState);
    assign scanStart  = (state == idleState) && bufferMiss;
    assign bufferLoad = scanActive && (entryHit || lastIndex); // match or give up at the end
    assign loadFound  = entryHit;

    always_comb begin
        nextState = state;
        case (state)
            idleState: if (bufferMiss) nextState = scanState;
            scanState: if (bufferLoad) nextState = idleState;
            default:   nextState = idleState;
        endcase
    end

    // the array must not change under a running scan
    noWriteInScan: assert property (
        @(posedge clk) disable iff (reset)
        scanActive |-> !writeStrobe
    ) else $error("joint TLB written during a refill scan");

    // every scan ends in a load within one pass over the array
    scanEndsInLoad: assert property (
        @(posedge clk) disable iff (reset)
        scanStart |-> ##[1:`TLB_ENTRIES] bufferLoad
    ) else $error("refill scan did not end with a buffer load");

endmodule

// ==== source/tlbScanCounter.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlbScanCounter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    scanStart,
    input  logic                    scanActive,
    output logic [`TLB_INDEX_W-1:0] scanIndex,
    output logic                    lastIndex
);

    assign lastIndex = (scanIndex == `TLB_INDEX_W'(`TLB_ENTRIES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            scanIndex <= '0;
        end else if (scanStart) begin
            scanIndex <= '0; // scan always begins at entry 0
        end else if (scanActive && !lastIndex) begin
            scanIndex <= scanIndex + 1'b1;
        end
    end

    // the index stops at the last entry so the scan has to end there
    scanStopsAtLast: assert property (
        @(posedge clk) disable iff (reset)
        (scanActive && lastIndex) |=> !scanActive
    ) else $error("scan ran on past the last joint TLB entry");

endmodule

// ==== source/tlbEntryArray.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlbEntryArray (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    writeStrobe,
    input  mmuPkg::tlbWrite_t       tlbWrite,
    input  logic [`TLB_INDEX_W-1:0] scanIndex,
    input  logic [18:0]             vpn2,
    output logic                    entryHit,
    output mmuPkg::tlbEntry_t       readEntry
);

    mmuPkg::tlbEntry_t entries [`TLB_ENTRIES];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i].vpn2 <= '0;
                entries[i].v0   <= 1'b0;
                entries[i].v1   <= 1'b0;
            end
        end else if (writeStrobe) begin
            entries[tlbWrite.index] <= tlbWrite.entry; // visible from next cycle
        end
    end

    assign readEntry = entries[scanIndex];
    assign entryHit  = (readEntry.vpn2 == vpn2); // invalid pages still match

endmodule

// ==== source/mmuPkg.sv ====
`include "mmu_defs.svh"

package mmuPkg;

    // one joint TLB entry holding an even/odd page pair
    typedef struct packed {
        logic [18:0] vpn2;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlbEntry_t;

    typedef struct packed {
        logic [19:0] vpn;   // virtual address bits 31..12
        logic        read;
        logic        store;
    } dataAccess_t;

    typedef enum logic [2:0] {
        noEx,
        rdRefill,
        wrRefill,
        rdInvalid,
        wrInvalid,
        modified
    } tlbException_e;

    typedef struct packed {
        logic [19:0]   pfn;
        logic          uncached;
        tlbException_e exception;
        logic          ex;
    } translation_t;

    typedef struct packed {
        logic [`TLB_INDEX_W-1:0] index;
        tlbEntry_t               entry;
    } tlbWrite_t;

endpackage

// ==== source/mmu_defs.svh ====
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// joint TLB size
`define TLB_ENTRIES 8
`define TLB_INDEX_W 3

// cache attribute code that marks a page cacheable
`define CACHEABLE_ATTR 3'd3

// upper three bits of the segment nibble
`define KSEG0_HI 3'b100 // 0x8 and 0x9
`define KSEG1_HI 3'b101 // 0xA and 0xB

`endif
